//--- cache_pkg.sv
package cache_pkg;

    // Geometry
    localparam int num_ways    = 4;
    localparam int num_sets    = 16;
    localparam int offset_bits = 5;                            // 32-byte lines
    localparam int index_bits  = 4;
    localparam int tag_bits    = 32 - index_bits - offset_bits;

    typedef logic [31:0]                     addr_t;
    typedef logic [31:0]                     word_t;
    typedef logic [8*(1<<offset_bits)-1:0]   line_t;           // 256 bits
    typedef logic [3:0]                      byte_mask_t;
    typedef logic [(1<<offset_bits)-1:0]     line_mask_t;      // One bit per line byte
    typedef logic [tag_bits-1:0]             tag_t;
    typedef logic [index_bits-1:0]           set_idx_t;
    typedef logic [$clog2(num_ways)-1:0]     way_idx_t;
    typedef logic [num_ways-2:0]             plru_t;           // Tree bits of one set

    // MESI line state, invalid is the reset value
    typedef enum logic [1:0] {
        mesi_invalid   = 2'b00,
        mesi_shared    = 2'b01,
        mesi_exclusive = 2'b10,
        mesi_modified  = 2'b11
    } mesi_t;

    // Per-line metadata as kept by line_store
    typedef struct packed {
        mesi_t state;
        logic  dirty;
        tag_t  tag;
    } line_meta_t;

endpackage

//--- bus_pkg.sv
package bus_pkg;

    // Commands carried on the snoop bus
    typedef enum logic [1:0] {
        cmd_none    = 2'b00,
        cmd_bus_rd  = 2'b01,     // Read line, holders go Shared
        cmd_bus_inv = 2'b10      // Invalidate other copies
    } bus_cmd_t;

    // Answer to an outgoing command
    typedef enum logic [1:0] {
        resp_none = 2'b00,
        resp_hit  = 2'b01,
        resp_miss = 2'b10
    } bus_resp_t;

    typedef struct packed {
        cache_pkg::addr_t addr;
        bus_cmd_t         cmd;
    } bus_req_t;

endpackage

//--- line_store.sv
module line_store (
    input  logic                                              clk,
    input  logic                                              rst,
    input  cache_pkg::set_idx_t                               cpu_set,
    input  cache_pkg::way_idx_t                               cpu_way,
    input  logic                                              cpu_data_we,
    input  logic                                              cpu_meta_we,
    input  cache_pkg::line_mask_t                             cpu_wmask,
    input  cache_pkg::line_t                                  cpu_wdata,
    input  cache_pkg::line_meta_t                             cpu_meta_in,
    input  cache_pkg::set_idx_t                               snp_set,
    input  cache_pkg::way_idx_t                               snp_way,
    input  logic                                              snp_meta_we,
    input  cache_pkg::line_meta_t                             snp_meta_in,
    output cache_pkg::line_meta_t [cache_pkg::num_ways-1:0]   cpu_meta,
    output cache_pkg::line_t      [cache_pkg::num_ways-1:0]   cpu_line,
    output cache_pkg::line_meta_t [cache_pkg::num_ways-1:0]   snp_meta,
    output cache_pkg::line_t      [cache_pkg::num_ways-1:0]   snp_line
);
    import cache_pkg::*;

    mesi_t state_q [num_ways][num_sets];
    logic  dirty_q [num_ways][num_sets];
    tag_t  tag_q   [num_ways][num_sets];
    line_t data_q  [num_ways][num_sets];

    // State and dirty bits are the only part cleared by reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < num_ways; w++) begin
                for (int s = 0; s < num_sets; s++) begin
                    state_q[w][s] <= mesi_invalid;
                    dirty_q[w][s] <= 1'b0;
                end
            end
        end else begin
            if (cpu_meta_we) begin
                state_q[cpu_way][cpu_set] <= cpu_meta_in.state;
                dirty_q[cpu_way][cpu_set] <= cpu_meta_in.dirty;
            end
            if (snp_meta_we) begin
                state_q[snp_way][snp_set] <= snp_meta_in.state;
                dirty_q[snp_way][snp_set] <= snp_meta_in.dirty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_meta_we) tag_q[cpu_way][cpu_set] <= cpu_meta_in.tag;
        if (snp_meta_we) tag_q[snp_way][snp_set] <= snp_meta_in.tag;
        if (cpu_data_we) begin
            for (int b = 0; b < (1 << offset_bits); b++) begin
                if (cpu_wmask[b]) data_q[cpu_way][cpu_set][8*b +: 8] <= cpu_wdata[8*b +: 8];
            end
        end
    end

    // Combinational reads for both ports
    for (genvar w = 0; w < num_ways; w++) begin : g_read
        assign cpu_meta[w] = '{state_q[w][cpu_set], dirty_q[w][cpu_set], tag_q[w][cpu_set]};
        assign cpu_line[w] = data_q[w][cpu_set];
        assign snp_meta[w] = '{state_q[w][snp_set], dirty_q[w][snp_set], tag_q[w][snp_set]};
        assign snp_line[w] = data_q[w][snp_set];
    end

    // Snoops are only taken while the controller leaves the arrays alone
    a_no_port_clash : assert property (@(posedge clk) disable iff (rst)
        !(cpu_meta_we && snp_meta_we && cpu_set == snp_set && cpu_way == snp_way));

endmodule

//--- plru_tree.sv
module plru_tree (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::set_idx_t set_idx,
    input  logic                touch,
    input  cache_pkg::way_idx_t touch_way,
    output cache_pkg::way_idx_t victim
);
    import cache_pkg::*;

    plru_t tree_q [num_sets];
    plru_t cur;
    plru_t nxt;

    assign cur = tree_q[set_idx];

    // Point the tree away from the way just used
    always_comb begin
        case (touch_way)
            2'd0:    nxt = {1'b1, 1'b1, cur[0]};
            2'd1:    nxt = {1'b1, 1'b0, cur[0]};
            2'd2:    nxt = {1'b0, cur[1], 1'b1};
            default: nxt = {1'b0, cur[1], 1'b0};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) tree_q[s] <= '0;
        end else if (touch) begin
            tree_q[set_idx] <= nxt;
        end
    end

    // bit2 picks the half, bit1 or bit0 the way within it
    assign victim = cur[2] ? (cur[0] ? 2'd3 : 2'd2)
                           : (cur[1] ? 2'd1 : 2'd0);

endmodule

//--- cache_ctrl.sv
module cache_ctrl (
    input  logic                                              clk,
    input  logic                                              rst,
    input  cache_pkg::addr_t                                  ufp_addr,
    input  cache_pkg::byte_mask_t                             ufp_rmask,
    input  cache_pkg::byte_mask_t                             ufp_wmask,
    input  cache_pkg::word_t                                  ufp_wdata,
    output cache_pkg::word_t                                  ufp_rdata,
    output logic                                              ufp_resp,
    input  cache_pkg::line_meta_t [cache_pkg::num_ways-1:0]   cpu_meta,
    input  cache_pkg::line_t      [cache_pkg::num_ways-1:0]   cpu_line,
    input  cache_pkg::way_idx_t                               victim,
    output cache_pkg::addr_t                                  dfp_addr,
    output logic                                              dfp_read,
    output logic                                              dfp_write,
    output cache_pkg::line_t                                  dfp_wdata,
    input  cache_pkg::line_t                                  dfp_rdata,
    input  logic                                              dfp_resp,
    output logic                                              bus_query,
    input  logic                                              bus_grant,
    output bus_pkg::bus_req_t                                 bus_req,
    input  bus_pkg::bus_resp_t                                bus_resp,
    input  cache_pkg::line_t                                  bus_fill_data,
    output cache_pkg::set_idx_t                               cpu_set,
    output cache_pkg::way_idx_t                               cpu_way,
    output logic                                              cpu_data_we,
    output logic                                              cpu_meta_we,
    output cache_pkg::line_mask_t                             cpu_wmask,
    output cache_pkg::line_t                                  cpu_wdata,
    output cache_pkg::line_meta_t                             cpu_meta_in,
    output logic                                              touch,
    output cache_pkg::way_idx_t                               touch_way,
    output logic                                              snoop_block
);
    import cache_pkg::*;
    import bus_pkg::*;

    typedef enum logic [3:0] {
        idle, compare, write_back, acquire_bus_read, bus_read,
        allocate, stall, acquire_bus_write, broadcast_write
    } ctrl_state_t;

    ctrl_state_t state, next_state;

    tag_t               addr_tag;
    logic [2:0]         word_sel;
    logic [num_ways-1:0] way_hit;
    logic               hit;
    way_idx_t           hit_way;
    logic               is_write;
    logic               upgrade;      // Write hit on a Shared line
    logic               victim_dirty;
    word_t              rmask_ext;

    assign addr_tag = ufp_addr[31 -: tag_bits];
    assign cpu_set  = ufp_addr[offset_bits +: index_bits];
    assign word_sel = ufp_addr[4:2];
    assign is_write = |ufp_wmask;

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_hit[w] = (cpu_meta[w].state != mesi_invalid) && (cpu_meta[w].tag == addr_tag);
        end
        hit = |way_hit;
        if (way_hit[0])      hit_way = 2'd0;   // Same priority as the snoop side
        else if (way_hit[2]) hit_way = 2'd2;
        else if (way_hit[1]) hit_way = 2'd1;
        else                 hit_way = 2'd3;
        for (int b = 0; b < 4; b++) rmask_ext[8*b +: 8] = {8{ufp_rmask[b]}};
    end

    assign upgrade      = hit && is_write && cpu_meta[hit_way].state == mesi_shared;
    assign victim_dirty = cpu_meta[victim].state != mesi_invalid && cpu_meta[victim].dirty;
    assign touch_way    = hit_way;

    always_ff @(posedge clk) begin
        if (rst) state <= idle;
        else     state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            idle:              if (|ufp_rmask || is_write) next_state = compare;
            compare: begin
                if (upgrade)           next_state = acquire_bus_write;
                else if (hit)          next_state = idle;
                else if (victim_dirty) next_state = write_back;
                else                   next_state = acquire_bus_read;
            end
            write_back:        if (dfp_resp) next_state = acquire_bus_read;
            acquire_bus_read:  if (bus_grant) next_state = bus_read;
            bus_read: begin
                if (bus_resp == resp_hit)       next_state = stall;
                else if (bus_resp == resp_miss) next_state = allocate;
            end
            allocate:          if (dfp_resp) next_state = stall;
            stall:             next_state = compare;
            acquire_bus_write: if (bus_grant) next_state = broadcast_write;
            broadcast_write:   if (bus_resp != resp_none) next_state = compare;
            default:           next_state = idle;
        endcase
    end

    always_comb begin
        ufp_resp    = 1'b0;
        ufp_rdata   = '0;
        dfp_read    = 1'b0;
        dfp_write   = 1'b0;
        dfp_addr    = '0;
        dfp_wdata   = '0;
        bus_query   = 1'b0;
        bus_req     = '{addr: '0, cmd: cmd_none};
        cpu_data_we = 1'b0;
        cpu_meta_we = 1'b0;
        cpu_way     = victim;                                 // Fills go to the victim
        cpu_wmask   = '1;
        cpu_wdata   = dfp_rdata;
        cpu_meta_in = '{state: mesi_exclusive, dirty: 1'b0, tag: addr_tag};
        touch       = 1'b0;
        snoop_block = 1'b0;
        case (state)
            compare: if (hit) begin
                cpu_way   = hit_way;
                touch     = 1'b1;
                ufp_rdata = cpu_line[hit_way][32*word_sel +: 32] & rmask_ext;
                ufp_resp  = !upgrade;                         // Upgrade answers after bus_inv
                if (is_write) begin
                    cpu_data_we = 1'b1;
                    cpu_meta_we = 1'b1;
                    cpu_wmask   = line_mask_t'(ufp_wmask) << (4*word_sel);
                    cpu_wdata   = {8{ufp_wdata}};
                    cpu_meta_in = '{state: mesi_modified, dirty: 1'b1, tag: addr_tag};
                end
            end
            write_back: begin
                dfp_write = 1'b1;
                dfp_addr  = {cpu_meta[victim].tag, cpu_set, {offset_bits{1'b0}}};
                dfp_wdata = cpu_line[victim];
            end
            acquire_bus_read, acquire_bus_write: bus_query = 1'b1;
            bus_read: begin
                snoop_block = 1'b1;
                bus_req     = '{addr: ufp_addr, cmd: cmd_bus_rd};
                if (bus_resp == resp_hit) begin               // Another cache supplies the line
                    cpu_data_we = 1'b1;
                    cpu_meta_we = 1'b1;
                    cpu_wdata   = bus_fill_data;
                    cpu_meta_in = '{state: mesi_shared, dirty: 1'b0, tag: addr_tag};
                end
            end
            allocate: begin
                dfp_read = 1'b1;
                dfp_addr = {ufp_addr[31:offset_bits], {offset_bits{1'b0}}};
                if (dfp_resp) begin
                    cpu_data_we = 1'b1;
                    cpu_meta_we = 1'b1;
                end
            end
            broadcast_write: begin
                snoop_block = 1'b1;
                bus_req     = '{addr: ufp_addr, cmd: cmd_bus_inv};
            end
            default: ;
        endcase
    end

    a_dfp_exclusive : assert property (@(posedge clk) disable iff (rst)
        !(dfp_read && dfp_write));

    // Bus command stays put until answered
    a_bus_req_held : assert property (@(posedge clk) disable iff (rst)
        (bus_req.cmd != cmd_none && bus_resp == resp_none) |=> $stable(bus_req));

endmodule

//--- snoop_port.sv
module snoop_port (
    input  bus_pkg::bus_req_t                                 snoop_req,
    input  logic                                              snoop_block,
    input  cache_pkg::line_meta_t [cache_pkg::num_ways-1:0]   snp_meta,
    input  cache_pkg::line_t      [cache_pkg::num_ways-1:0]   snp_line,
    output cache_pkg::set_idx_t                               snp_set,
    output cache_pkg::way_idx_t                               snp_way,
    output logic                                              snp_meta_we,
    output cache_pkg::line_meta_t                             snp_meta_in,
    output logic                                              snoop_hit,
    output cache_pkg::line_t                                  snoop_data
);
    import cache_pkg::*;
    import bus_pkg::*;

    tag_t                snp_tag;
    logic [num_ways-1:0] way_hit;
    logic                active;

    assign snp_tag = snoop_req.addr[31 -: tag_bits];
    assign snp_set = snoop_req.addr[offset_bits +: index_bits];
    assign active  = !snoop_block && snoop_req.cmd != cmd_none;

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_hit[w] = (snp_meta[w].state != mesi_invalid) && (snp_meta[w].tag == snp_tag);
        end
        if (way_hit[0])      snp_way = 2'd0;
        else if (way_hit[2]) snp_way = 2'd2;
        else if (way_hit[1]) snp_way = 2'd1;
        else                 snp_way = 2'd3;
    end

    assign snoop_hit   = active && |way_hit;
    assign snp_meta_we = snoop_hit;                           // Lands on the next edge

    always_comb begin
        snp_meta_in = snp_meta[snp_way];                      // Dirty and tag kept
        snoop_data  = '0;
        if (snoop_req.cmd == cmd_bus_rd) begin
            snp_meta_in.state = mesi_shared;
            if (snoop_hit) snoop_data = snp_line[snp_way];
        end else begin
            snp_meta_in.state = mesi_invalid;
        end
    end

endmodule

//--- snoop_d_cache.sv
module snoop_d_cache (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::addr_t      ufp_addr,
    input  cache_pkg::byte_mask_t ufp_rmask,
    input  cache_pkg::byte_mask_t ufp_wmask,
    output cache_pkg::word_t      ufp_rdata,
    input  cache_pkg::word_t      ufp_wdata,
    output logic                  ufp_resp,
    output cache_pkg::addr_t      dfp_addr,
    output logic                  dfp_read,
    output logic                  dfp_write,
    input  cache_pkg::line_t      dfp_rdata,
    output cache_pkg::line_t      dfp_wdata,
    input  logic                  dfp_resp,
    output logic                  bus_query,
    input  logic                  bus_grant,
    input  bus_pkg::bus_resp_t    bus_resp,
    input  cache_pkg::line_t      bus_fill_data,
    output bus_pkg::bus_req_t     bus_req,
    input  bus_pkg::bus_req_t     snoop_req,
    output logic                  snoop_hit,
    output cache_pkg::line_t      snoop_data
);
    import cache_pkg::*;

    line_meta_t [num_ways-1:0] cpu_meta, snp_meta;
    line_t      [num_ways-1:0] cpu_line, snp_line;
    set_idx_t   cpu_set, snp_set;
    way_idx_t   cpu_way, snp_way, victim, touch_way;
    logic       cpu_data_we, cpu_meta_we, snp_meta_we, touch, snoop_block;
    line_mask_t cpu_wmask;
    line_t      cpu_wdata;
    line_meta_t cpu_meta_in, snp_meta_in;

    cache_ctrl u_ctrl (.*);

    snoop_port u_snoop (.*);

    line_store u_store (.*);

    // Replacement tracks the set the CPU is addressing
    plru_tree u_plru (
        .clk       (clk),
        .rst       (rst),
        .set_idx   (cpu_set),
        .touch     (touch),
        .touch_way (touch_way),
        .victim    (victim)
    );

endmodule

//--- tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst
);

    // 20 unit period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);                 // Released away from the active edge
        rst = 1'b0;
    end

endmodule

//--- snoop_d_cache_tb.sv
module snoop_d_cache_tb;
    import cache_pkg::*;
    import bus_pkg::*;

    logic       clk;
    logic       rst;
    addr_t      ufp_addr;
    byte_mask_t ufp_rmask;
    byte_mask_t ufp_wmask;
    word_t      ufp_wdata;
    word_t      ufp_rdata;
    logic       ufp_resp;
    addr_t      dfp_addr;
    logic       dfp_read;
    logic       dfp_write;
    line_t      dfp_rdata = '0;
    line_t      dfp_wdata;
    logic       dfp_resp = 1'b0;
    logic       bus_query;
    logic       bus_grant = 1'b0;
    bus_resp_t  bus_resp = resp_none;
    line_t      bus_fill_data = '0;
    bus_req_t   bus_req;
    bus_req_t   snoop_req;
    logic       snoop_hit;
    line_t      snoop_data;

    line_t       mem [addr_t];          // Line-aligned keys
    int unsigned lcg_state = 28;        // Seed
    int          mem_wait, mem_seq, rd_seq, wr_seq, rd_count, wr_count;
    addr_t       last_rd_addr;
    addr_t       last_wr_addr;
    bus_resp_t   bus_answer;            // Programmed per test
    line_t       bus_line;
    int          grant_wait, resp_wait, query_count, bus_count;
    bus_req_t    last_bus_req = '0;
    line_t       a_model;               // Line of the shared test address as the CPU wrote it
    string       test_name;
    int          test_errors, error_count, checks_run, test_count, failed_tests;

    tb_clock clock_gen (.clk(clk), .rst(rst));

    snoop_d_cache dut (.*);

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Untouched lines get LCG words mixed with their own address
    function automatic line_t mem_line(addr_t a);
        addr_t la;
        line_t l;
        la = {a[31:offset_bits], {offset_bits{1'b0}}};
        if (!mem.exists(la)) begin
            for (int w = 0; w < 8; w++) l[32*w +: 32] = lcg_next() ^ la ^ word_t'(w);
            mem[la] = l;
        end
        return mem[la];
    endfunction

    function automatic word_t word_of(line_t l, addr_t a);
        return l[32*a[4:2] +: 32];
    endfunction

    function automatic word_t merge_bytes(word_t old, word_t wd, byte_mask_t m, logic keep_old);
        word_t r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = m[b] ? wd[8*b +: 8] : (keep_old ? old[8*b +: 8] : 8'h00);
        end
        return r;
    endfunction

    // Tree bits: bit2 selects the half, bit1 the low pair, bit0 the high pair
    function automatic plru_t plru_touch(plru_t t, way_idx_t w);
        case (w)
            2'd0:    return {2'b11, t[0]};
            2'd1:    return {2'b10, t[0]};
            2'd2:    return {1'b0, t[1], 1'b1};
            default: return {1'b0, t[1], 1'b0};
        endcase
    endfunction

    function automatic way_idx_t plru_victim(plru_t t);
        if (!t[2]) return t[1] ? 2'd1 : 2'd0;
        return t[0] ? 2'd3 : 2'd2;
    endfunction

    // Memory answers on the third falling edge of a request
    always @(negedge clk) begin
        dfp_resp <= 1'b0;
        if (!rst && (dfp_read || dfp_write) && !dfp_resp) begin
            if (mem_wait < 2) begin
                mem_wait <= mem_wait + 1;
            end else begin
                mem_wait <= 0;
                dfp_resp <= 1'b1;
                mem_seq  <= mem_seq + 1;
                if (dfp_write) begin
                    mem[dfp_addr] = dfp_wdata;
                    last_wr_addr <= dfp_addr;
                    wr_seq   <= mem_seq;
                    wr_count <= wr_count + 1;
                end else begin
                    dfp_rdata    <= mem_line(dfp_addr);
                    last_rd_addr <= dfp_addr;
                    rd_seq       <= mem_seq;
                    rd_count     <= rd_count + 1;
                end
            end
        end
    end

    // Bus arbiter and the other caches
    always @(negedge clk) begin
        bus_resp <= resp_none;
        if (!bus_query) begin
            bus_grant  <= 1'b0;
            grant_wait <= 0;
        end else if (!bus_grant) begin
            if (grant_wait < 2) grant_wait <= grant_wait + 1;
            else bus_grant <= 1'b1;
        end
        if (bus_req.cmd != cmd_none && bus_resp == resp_none) begin
            if (resp_wait < 1) begin
                resp_wait <= resp_wait + 1;
            end else begin
                resp_wait     <= 0;
                bus_resp      <= (bus_req.cmd == cmd_bus_rd) ? bus_answer : resp_hit;
                bus_fill_data <= bus_line;
                last_bus_req  <= bus_req;
                bus_count     <= bus_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (bus_query) query_count <= query_count + 1;
    end

    task automatic note_error(string msg);
        test_errors++;
        $display("** Error %s: %s", test_name, msg);
    endtask

    task automatic check_word(string what, word_t exp, word_t act);
        checks_run++;
        if (exp !== act) note_error($sformatf("%s expected %h actual %h", what, exp, act));
    endtask

    task automatic check_line(string what, line_t exp, line_t act);
        checks_run++;
        if (exp !== act) note_error($sformatf("%s expected %h actual %h", what, exp, act));
    endtask

    task automatic check_addr(string what, addr_t exp, addr_t act);
        checks_run++;
        if (exp !== act) note_error($sformatf("%s expected %h actual %h", what, exp, act));
    endtask

    task automatic check_cmd(string what, bus_cmd_t exp, bus_cmd_t act);
        checks_run++;
        if (exp !== act) note_error($sformatf("%s expected %h actual %h", what, exp, act));
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        checks_run++;
        if (exp !== act) note_error($sformatf("%s expected %b actual %b", what, exp, act));
    endtask

    task automatic check_count(string what, int exp, int act);
        checks_run++;
        if (exp != act) note_error($sformatf("%s expected %0d actual %0d", what, exp, act));
    endtask

    task automatic start_test(string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        test_count++;
        error_count += test_errors;
        if (test_errors == 0) begin
            $display("%s: passed", test_name);
        end else begin
            failed_tests++;
            $display("%s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (rst && cycles < 20);
        if (rst) begin
            error_count++;
            $display("Reset was never released");
        end
    endtask

    // Request held until ufp_resp, dropped on the falling edge after it
    task automatic cpu_access(addr_t a, byte_mask_t rm, byte_mask_t wm, word_t wd,
                              output word_t rd);
        int cycles;
        cycles = 0;
        rd     = '0;
        @(negedge clk);
        ufp_addr  = a;
        ufp_rmask = rm;
        ufp_wmask = wm;
        ufp_wdata = wd;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ufp_resp && cycles < 300);
        if (ufp_resp) begin
            rd = ufp_rdata;
        end else begin
            test_errors++;
            $display("%s: request to %h got no ufp_resp in 300 cycles", test_name, a);
        end
        @(negedge clk);
        ufp_rmask = '0;
        ufp_wmask = '0;
    endtask

    // One snoop cycle, answer sampled mid-cycle
    task automatic snoop_probe(addr_t a, bus_cmd_t c, output logic hit, output line_t data);
        @(negedge clk);
        snoop_req = '{addr: a, cmd: c};
        #5;
        hit  = snoop_hit;
        data = snoop_data;
        @(negedge clk);
        snoop_req = '{addr: '0, cmd: cmd_none};
    endtask

    task automatic read_miss_memory();
        addr_t a;
        word_t rd;
        line_t l;
        int    rds, wrs, qs;
        a = 32'h0000_1024;
        start_test("read_miss_memory");
        l          = mem_line(a);
        bus_answer = resp_miss;
        rds        = rd_count;
        cpu_access(a, 4'b1011, 4'b0000, '0, rd);
        check_word("read data", merge_bytes('0, word_of(l, a), 4'b1011, 1'b0), rd);
        check_cmd("bus command", cmd_bus_rd, last_bus_req.cmd);
        check_addr("bus address", a, last_bus_req.addr);
        check_addr("fill address", 32'h0000_1020, last_rd_addr);
        check_count("memory reads", rds + 1, rd_count);
        rds = rd_count;
        wrs = wr_count;
        qs  = query_count;
        cpu_access(a + 4, 4'b1111, 4'b0000, '0, rd);
        check_word("hit data", word_of(l, a + 4), rd);
        check_count("memory reads on hit", rds, rd_count);
        check_count("memory writes on hit", wrs, wr_count);
        check_count("bus queries on hit", qs, query_count);
        end_test();
    endtask

    task automatic write_hit_exclusive();
        addr_t a;
        word_t rd;
        word_t exp;
        int    qs;
        a = 32'h0000_1024;
        start_test("write_hit_exclusive");
        a_model = mem_line(a);
        exp     = merge_bytes(word_of(a_model, a), 32'hAABB_CCDD, 4'b0110, 1'b1);
        a_model[32*a[4:2] +: 32] = exp;
        qs = query_count;
        cpu_access(a, 4'b0000, 4'b0110, 32'hAABB_CCDD, rd);
        check_count("bus queries on write", qs, query_count);
        cpu_access(a, 4'b1111, 4'b0000, '0, rd);
        check_word("merged word", exp, rd);
        end_test();
    endtask

    task automatic bus_fill_upgrade();
        addr_t a;
        word_t rd;
        int    rds, bc;
        a = 32'h0000_2048;                                  // Set 2, word 2
        start_test("bus_fill_upgrade");
        for (int w = 0; w < 8; w++) bus_line[32*w +: 32] = lcg_next();
        bus_answer = resp_hit;
        rds        = rd_count;
        cpu_access(a, 4'b1111, 4'b0000, '0, rd);
        check_word("bus fill data", word_of(bus_line, a), rd);
        check_cmd("bus command", cmd_bus_rd, last_bus_req.cmd);
        check_count("memory reads", rds, rd_count);
        bc = bus_count;
        cpu_access(a, 4'b0000, 4'b1111, 32'h1234_5678, rd);
        check_count("bus commands on upgrade", bc + 1, bus_count);
        check_cmd("upgrade command", cmd_bus_inv, last_bus_req.cmd);
        check_addr("upgrade address", a, last_bus_req.addr);
        cpu_access(a, 4'b1111, 4'b0000, '0, rd);
        check_word("read after upgrade", 32'h1234_5678, rd);
        bus_answer = resp_miss;
        end_test();
    endtask

    task automatic plru_eviction();
        addr_t    owner  [num_ways];
        word_t    stored [num_ways];
        addr_t    a;
        word_t    rd;
        line_t    exp_line;
        plru_t    tree;
        way_idx_t v;
        int       wrs;
        start_test("plru_eviction");
        bus_answer = resp_miss;
        tree       = '0;
        for (int i = 0; i < num_ways; i++) begin
            a         = 32'h0000_20A0 + 32'h200 * i;            // All in set 5
            v         = plru_victim(tree);
            owner[v]  = a;
            stored[v] = lcg_next();
            cpu_access(a, 4'b0000, 4'b1111, stored[v], rd);
            tree = plru_touch(tree, v);
        end
        v        = plru_victim(tree);
        exp_line = mem_line(owner[v]);
        exp_line[31:0] = stored[v];
        a   = 32'h0000_28A0;
        wrs = wr_count;
        cpu_access(a, 4'b1111, 4'b0000, '0, rd);
        check_count("write-backs", wrs + 1, wr_count);
        check_addr("write-back address", owner[v], last_wr_addr);
        check_line("write-back data", exp_line, mem[owner[v]]);
        check_addr("fill address", a, last_rd_addr);
        check_bit("write-back before fill", 1'b1, wr_seq < rd_seq);
        check_word("read after eviction", word_of(mem_line(a), a), rd);
        end_test();
    endtask

    task automatic snoop_coherence();
        addr_t a;
        word_t rd;
        logic  hit;
        line_t data;
        int    bc;
        a = 32'h0000_1024;
        start_test("snoop_coherence");
        snoop_probe(a, cmd_bus_rd, hit, data);
        check_bit("snoop_hit on bus_rd", 1'b1, hit);
        check_line("snoop data", a_model, data);
        snoop_probe(a, cmd_bus_inv, hit, data);
        check_bit("snoop_hit on bus_inv", 1'b1, hit);
        bus_answer = resp_miss;
        bc         = bus_count;
        cpu_access(a, 4'b1111, 4'b0000, '0, rd);
        check_count("bus commands after invalidate", bc + 1, bus_count);
        check_cmd("command after invalidate", cmd_bus_rd, last_bus_req.cmd);
        check_addr("address after invalidate", a, last_bus_req.addr);
        snoop_probe(32'h0000_3024, cmd_bus_rd, hit, data);
        check_bit("snoop_hit on absent line", 1'b0, hit);
        end_test();
    endtask

    initial begin
        ufp_addr   = '0;
        ufp_rmask  = '0;
        ufp_wmask  = '0;
        ufp_wdata  = '0;
        snoop_req  = '{addr: '0, cmd: cmd_none};
        bus_answer = resp_miss;
        bus_line   = '0;
        wait_reset();
        read_miss_memory();
        write_hit_exclusive();
        bus_fill_upgrade();
        plru_eviction();
        snoop_coherence();
        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, checks_run, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- snoop_d_cache.f
cache_pkg.sv
bus_pkg.sv
line_store.sv
plru_tree.sv
cache_ctrl.sv
snoop_port.sv
snoop_d_cache.sv
tb_clock.sv
snoop_d_cache_tb.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module snoop_d_cache_tb -f snoop_d_cache.f

run: build
	./obj_dir/Vsnoop_d_cache_tb | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module snoop_d_cache_tb -f snoop_d_cache.f

clean:
	rm -rf obj_dir sim.log
